/* hdl/afifo_geom_pkg.sv */
//////////////////////////////
// storage geometry and word types of the dual-clock FIFO
// referenced by scoped name from every RTL file
//////////////////////////////

package afifo_geom_pkg;

	//////////////////////////////
	// geometry
	//////////////////////////////

	// width of one stored word
	localparam int DATA_WIDTH = 32;

	// depth, kept a power of two and at least 4
	// so the full test on the top two pointer bits holds
	localparam int NUM_ENTRIES = 8;

	// entry index bits, plus one wrap bit for the pointers
	localparam int ADDR_WIDTH = $clog2(NUM_ENTRIES);
	localparam int PTR_WIDTH  = ADDR_WIDTH + 1;

	// one stored word
	typedef logic [DATA_WIDTH-1:0] data_t;
	// entry index into the array
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	// pointer with the wrap bit on top
	typedef logic [PTR_WIDTH-1:0]  ptr_t;

endpackage

/* hdl/afifo_sync_pkg.sv */
//////////////////////////////
// clock crossing types of the FIFO
// pointer state, write request and synchronizer depth
//////////////////////////////

package afifo_sync_pkg;

	// flops in every synchronizer chain
	localparam int SYNC_STAGES = 2;

	// pointer state of one side
	// only gray ever crosses to the other domain
	typedef struct packed {
		afifo_geom_pkg::ptr_t bin;
		afifo_geom_pkg::ptr_t gray;
	} ptr_state_t;

	// write request as the writer presents it
	// en high asks to store data this write_clk cycle
	typedef struct packed {
		logic                  en;
		afifo_geom_pkg::data_t data;
	} write_req_t;

endpackage

/* hdl/bit_synchronizer.sv */
//////////////////////////////
// multi-flop synchronizer for Gray pointers and for reset
//////////////////////////////

`timescale 1ns/1ps

module bit_synchronizer #(
	parameter int               WIDTH       = 1,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out
);

	// stage 0 samples the foreign signal, last stage is safe to use
	logic [afifo_sync_pkg::SYNC_STAGES-1:0][WIDTH-1:0] stage_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// for the reset chain this holds the output asserted
			stage_q <= {afifo_sync_pkg::SYNC_STAGES{RESET_VALUE}};
		end
		else
		begin
			// shift toward the top, new sample enters at 0
			stage_q <= {stage_q[afifo_sync_pkg::SYNC_STAGES-2:0], data_in};
		end
	end

	assign data_out = stage_q[afifo_sync_pkg::SYNC_STAGES-1];

endmodule

/* hdl/gray_pointer.sv */
//////////////////////////////
// binary and Gray pointer pair for one side of the FIFO
// steps by one on every accepted transfer
//////////////////////////////

`timescale 1ns/1ps

module gray_pointer (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      advance,
	output afifo_sync_pkg::ptr_state_t state,
	output afifo_geom_pkg::ptr_t       next_gray
);

	afifo_geom_pkg::ptr_t next_bin;

	// next binary value wraps through the extra bit
	assign next_bin  = state.bin + 1'b1;
	// binary to Gray, one bit changes per step
	assign next_gray = next_bin ^ (next_bin >> 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state.bin  <= '0;
			state.gray <= '0;
		end
		else if (advance)
		begin
			// both forms move together
			state.bin  <= next_bin;
			state.gray <= next_gray;
		end
	end

endmodule

/* hdl/fifo_storage.sv */
//////////////////////////////
// entry array of the FIFO, written on write_clk
// read into an output register on read_clk
//////////////////////////////

`timescale 1ns/1ps

module fifo_storage (
	input  logic                  write_clk,
	input  logic                  wr_en,
	input  afifo_geom_pkg::addr_t wr_addr,
	input  afifo_geom_pkg::data_t wr_data,
	input  logic                  read_clk,
	input  logic                  read_reset,
	input  logic                  rd_en,
	input  afifo_geom_pkg::addr_t rd_addr,
	output afifo_geom_pkg::data_t rd_data
);

	// the words themselves
	afifo_geom_pkg::data_t mem [afifo_geom_pkg::NUM_ENTRIES];

	// write port, wr_en already qualified against full
	always_ff @(posedge write_clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read port, loads the popped word on the accepting edge
	// and holds it until the next accepted read
	always_ff @(posedge read_clk)
	begin
		if (read_reset)
			rd_data <= '0;
		else if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/write_side_ctrl.sv */
//////////////////////////////
// write domain control of the FIFO
// write pointer, synchronized read pointer and registered full
//////////////////////////////

`timescale 1ns/1ps

module write_side_ctrl (
	input  logic                       write_clk,
	input  logic                       reset,
	input  afifo_sync_pkg::write_req_t write_req,
	input  afifo_geom_pkg::ptr_t       read_gray,
	output logic                       wr_en,
	output afifo_geom_pkg::addr_t      wr_addr,
	output afifo_geom_pkg::data_t      wr_data,
	output afifo_sync_pkg::ptr_state_t write_state,
	output logic                       full
);

	localparam int PW = afifo_geom_pkg::PTR_WIDTH;

	afifo_geom_pkg::ptr_t write_next_gray;
	afifo_geom_pkg::ptr_t read_gray_sync;
	// Gray distance between write and synchronized read pointer
	afifo_geom_pkg::ptr_t full_check;

	// a request while full is dropped here
	assign wr_en   = write_req.en && !full;
	assign wr_addr = write_state.bin[afifo_geom_pkg::ADDR_WIDTH-1:0];
	assign wr_data = write_req.data;

	gray_pointer write_ptr_i (
		.clk       (write_clk),
		.reset     (reset),
		.advance   (wr_en),
		.state     (write_state),
		.next_gray (write_next_gray)
	);

	// read pointer arrives in Gray, two flops into write_clk
	bit_synchronizer #(.WIDTH(PW), .RESET_VALUE('0)) read_ptr_sync_i (
		.clk      (write_clk),
		.reset    (reset),
		.data_in  (read_gray),
		.data_out (read_gray_sync)
	);

	// look ahead with the next pointer on an accepted write,
	// so full rises on the same edge that stores the last word
	always_ff @(posedge write_clk)
	begin
		if (reset)
			full_check <= '0;
		else if (wr_en)
			full_check <= write_next_gray ^ read_gray_sync;
		else
			full_check <= write_state.gray ^ read_gray_sync;
	end

	// NUM_ENTRIES apart in Gray means the top two bits differ, rest equal
	assign full = full_check[PW-1] && full_check[PW-2] && (full_check[PW-3:0] == '0);

endmodule

/* hdl/read_side_ctrl.sv */
//////////////////////////////
// read domain control of the FIFO
// read pointer, synchronized write pointer and empty
//////////////////////////////

`timescale 1ns/1ps

module read_side_ctrl (
	input  logic                       read_clk,
	input  logic                       read_reset,
	input  afifo_geom_pkg::ptr_t       write_gray,
	input  logic                       read_en,
	output logic                       rd_en,
	output afifo_geom_pkg::addr_t      rd_addr,
	output afifo_sync_pkg::ptr_state_t read_state,
	output logic                       empty
);

	afifo_geom_pkg::ptr_t write_gray_sync;

	// write pointer brought into read_clk in Gray
	bit_synchronizer #(.WIDTH(afifo_geom_pkg::PTR_WIDTH), .RESET_VALUE('0)) write_ptr_sync_i (
		.clk      (read_clk),
		.reset    (read_reset),
		.data_in  (write_gray),
		.data_out (write_gray_sync)
	);

	// equal pointers, wrap bit included, mean nothing stored
	// lags real writes by the synchronizer depth, never early
	assign empty = (write_gray_sync == read_state.gray);

	// a read while empty is ignored
	assign rd_en   = read_en && !empty;
	assign rd_addr = read_state.bin[afifo_geom_pkg::ADDR_WIDTH-1:0];

	// look-ahead output only serves the write side
	gray_pointer read_ptr_i (
		.clk       (read_clk),
		.reset     (read_reset),
		.advance   (rd_en),
		.state     (read_state),
		.next_gray ()
	);

endmodule

/* hdl/async_fifo_top.sv */
//////////////////////////////
// dual-clock FIFO, 8 words of 32 bits
// write side on write_clk, read side on read_clk
//////////////////////////////

`timescale 1ns/1ps

module async_fifo_top (
	// write side
	input  logic                       write_clk,
	input  logic                       reset_rsync,
	input  afifo_sync_pkg::write_req_t write_req,
	output logic                       full,
	// read side
	input  logic                       read_clk,
	input  logic                       read_en,
	output afifo_geom_pkg::data_t      read_data,
	output logic                       empty
);

	//////////////////////////////
	// internal wiring
	//////////////////////////////

	// reset as seen in the read domain
	logic read_reset_sync;

	// storage write port
	logic                  wr_en;
	afifo_geom_pkg::addr_t wr_addr;
	afifo_geom_pkg::data_t wr_data;

	// storage read port
	logic                  rd_en;
	afifo_geom_pkg::addr_t rd_addr;

	// pointer state of each side, only gray crosses
	afifo_sync_pkg::ptr_state_t write_state;
	afifo_sync_pkg::ptr_state_t read_state;

	//////////////////////////////
	// read reset
	//////////////////////////////

	// asserted at once, released SYNC_STAGES read_clk edges later
	bit_synchronizer #(.WIDTH(1), .RESET_VALUE(1'b1)) read_reset_sync_i (
		.clk      (read_clk),
		.reset    (reset_rsync),
		.data_in  (1'b0),
		.data_out (read_reset_sync)
	);

	//////////////////////////////
	// domains and storage
	//////////////////////////////

	write_side_ctrl write_ctrl_i (
		.write_clk   (write_clk),
		.reset       (reset_rsync),
		.write_req   (write_req),
		.read_gray   (read_state.gray),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.write_state (write_state),
		.full        (full)
	);

	read_side_ctrl read_ctrl_i (
		.read_clk   (read_clk),
		.read_reset (read_reset_sync),
		.write_gray (write_state.gray),
		.read_en    (read_en),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.read_state (read_state),
		.empty      (empty)
	);

	fifo_storage storage_i (
		.write_clk  (write_clk),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.read_clk   (read_clk),
		.read_reset (read_reset_sync),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (read_data)
	);

endmodule

/* test/async_fifo_props.sv */
//////////////////////////////
// concurrent checks on handshake and flags of the FIFO
// bound into every async_fifo_top instance
//////////////////////////////

`timescale 1ns/1ps

module async_fifo_props (
	input logic                  write_clk,
	input logic                  read_clk,
	input logic                  reset_rsync,
	input logic                  read_reset_sync,
	input logic                  wr_en,
	input logic                  rd_en,
	input logic                  full,
	input logic                  empty,
	input afifo_geom_pkg::data_t read_data,
	input afifo_geom_pkg::ptr_t  write_gray,
	input afifo_geom_pkg::ptr_t  read_gray
);

	// number of assertion failures so far
	int assert_failures = 0;

	// output register holds between accepted reads
	read_data_hold: assert property (@(posedge read_clk)
		disable iff (reset_rsync || read_reset_sync)
		!rd_en |=> $stable(read_data))
	else
	begin
		assert_failures++;
		$error("read_data changed without an accepted read");
	end

	// full only rises on an edge that stores a word
	full_needs_write: assert property (@(posedge write_clk)
		disable iff (reset_rsync)
		!full && !wr_en |=> !full)
	else
	begin
		assert_failures++;
		$error("full rose without an accepted write");
	end

	// with no word written since, the synchronizer cannot clear empty
	empty_needs_write: assert property (@(posedge read_clk)
		disable iff (reset_rsync || read_reset_sync)
		empty && (write_gray == read_gray) |=> empty)
	else
	begin
		assert_failures++;
		$error("empty fell without a prior write");
	end

	//////////////////////////////
	// reset values
	//////////////////////////////

	full_after_reset: assert property (@(posedge write_clk) reset_rsync |=> !full)
	else
	begin
		assert_failures++;
		$error("full not low after reset");
	end

	empty_after_reset: assert property (@(posedge read_clk)
		read_reset_sync |=> empty && (read_data == '0))
	else
	begin
		assert_failures++;
		$error("empty or read_data wrong after read reset");
	end

endmodule

// hook into the top level, internal nets taken from its scope
bind async_fifo_top async_fifo_props props_i (
	.write_clk       (write_clk),
	.read_clk        (read_clk),
	.reset_rsync     (reset_rsync),
	.read_reset_sync (read_reset_sync),
	.wr_en           (wr_en),
	.rd_en           (rd_en),
	.full            (full),
	.empty           (empty),
	.read_data       (read_data),
	.write_gray      (write_state.gray),
	.read_gray       (read_state.gray)
);

/* test/async_fifo_tb.sv */
//////////////////////////////
// testbench of the dual-clock FIFO
// fill, drain, random traffic against a queue model
//////////////////////////////

`timescale 1ns/1ps

module async_fifo_tb;

	localparam int N = afifo_geom_pkg::NUM_ENTRIES;
	// read clock half period, unrelated to the 100 ns write clock
	localparam int READ_HALF = 65;
	localparam int WORD_COUNT = 200;
	// budget in read periods, traffic plus fill, drain and reset
	localparam int TIMEOUT_NS = (WORD_COUNT * 4 + 100) * 2 * READ_HALF;

	logic                       write_clk;
	logic                       read_clk;
	logic                       reset_rsync;
	afifo_sync_pkg::write_req_t write_req;
	logic                       read_en;
	logic                       full;
	logic                       empty;
	afifo_geom_pkg::data_t      read_data;

	// words accepted and not yet read, oldest first
	afifo_geom_pkg::data_t model_q [$];
	// last word the read port should show
	afifo_geom_pkg::data_t last_word;
	int error_count;

	async_fifo_top dut_i (
		.write_clk   (write_clk),
		.reset_rsync (reset_rsync),
		.write_req   (write_req),
		.full        (full),
		.read_clk    (read_clk),
		.read_en     (read_en),
		.read_data   (read_data),
		.empty       (empty)
	);

	always #50 write_clk = ~write_clk;
	always #(READ_HALF) read_clk = ~read_clk;

	task automatic check_value(input string name, input afifo_geom_pkg::data_t actual,
		input afifo_geom_pkg::data_t expected);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// oldest accepted word leaves first
	function automatic afifo_geom_pkg::data_t expected_word();
		afifo_geom_pkg::data_t word;
		word = '0;
		if (model_q.size() == 0)
		begin
			error_count++;
			$display("error at %0t: read accepted while the model holds no word", $time);
		end
		else
			word = model_q.pop_front();
		return word;
	endfunction

	//////////////////////////////
	// model and compare
	//////////////////////////////

	// values seen here are the ones the DUT samples on this edge
	always @(posedge write_clk)
	begin
		if (!reset_rsync && write_req.en && !full)
			model_q.push_back(write_req.data);
	end

	// compare once read_data has settled, half a read period later
	always @(posedge read_clk)
	begin
		if (read_en && !empty)
			last_word = expected_word();
		if (read_en)
		begin
			@(negedge read_clk);
			check_value("read_data", read_data, last_word);
		end
	end

	// random writes until count words were accepted
	task automatic random_writes(input int count);
		int accepted;
		accepted = 0;
		while (accepted < count)
		begin
			@(posedge write_clk);
			if (write_req.en && !full)
				accepted++;
			write_req.en <= (accepted < count) && ($urandom % 4 != 0);
			write_req.data <= $urandom;
		end
	endtask

	// random reads until count words were taken
	task automatic random_reads(input int count);
		int taken;
		taken = 0;
		while (taken < count)
		begin
			@(posedge read_clk);
			if (read_en && !empty)
				taken++;
			read_en <= (taken < count) && ($urandom % 4 != 0);
		end
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout at %0t: traffic did not complete", $time);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h2d9b_0c46));
		write_clk = 1'b0;
		read_clk = 1'b0;
		reset_rsync = 1'b1;
		write_req = '0;
		read_en = 1'b0;
		last_word = '0;
		error_count = 0;
		repeat (2) @(posedge write_clk);
		reset_rsync <= 1'b0;
		// read reset lets go SYNC_STAGES read edges later
		repeat (afifo_sync_pkg::SYNC_STAGES + 2) @(posedge read_clk);
		@(negedge read_clk);
		check_value("full", full, 0);
		check_value("empty", empty, 1);
		check_value("read_data", read_data, 0);

		// fill with no reads, full rises with the last word
		for (int i = 0; i < N; i++)
		begin
			@(posedge write_clk);
			write_req.en <= 1'b1;
			write_req.data <= 32'h1000_0000 | i;
			@(posedge write_clk);
			write_req.en <= 1'b0;
			@(negedge write_clk);
			check_value("full", full, (i == N - 1));
		end
		// these are dropped
		@(posedge write_clk);
		write_req.en <= 1'b1;
		for (int i = 0; i < 3; i++)
		begin
			write_req.data <= 32'hbad0_0000 | i;
			@(posedge write_clk);
		end
		write_req.en <= 1'b0;
		@(negedge write_clk);
		check_value("full", full, 1);

		// drain, then three reads while empty
		@(posedge read_clk);
		read_en <= 1'b1;
		for (int i = 0; i < N + 3; i++)
		begin
			@(posedge read_clk);
			@(negedge read_clk);
			check_value("empty", empty, (i >= N - 1));
		end
		@(posedge read_clk);
		read_en <= 1'b0;

		// concurrent traffic, pointers wrap many times
		fork
			random_writes(WORD_COUNT);
			random_reads(WORD_COUNT);
		join

		// idle read side, flags settle
		repeat (2 * afifo_sync_pkg::SYNC_STAGES + 4) @(posedge read_clk);
		@(negedge read_clk);
		check_value("empty", empty, 1);
		check_value("full", full, 0);
		check_value("model size", model_q.size(), 0);

		$display("checks done, errors: %0d, assertion failures: %0d",
			error_count, dut_i.props_i.assert_failures);
		if (error_count == 0 && dut_i.props_i.assert_failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* build.f */
hdl/afifo_geom_pkg.sv
hdl/afifo_sync_pkg.sv
hdl/bit_synchronizer.sv
hdl/gray_pointer.sv
hdl/fifo_storage.sv
hdl/write_side_ctrl.sv
hdl/read_side_ctrl.sv
hdl/async_fifo_top.sv
test/async_fifo_props.sv
test/async_fifo_tb.sv

/* Bender.yml */
package:
  name: async_fifo

sources:
  # RTL, packages first
  - files:
      - hdl/afifo_geom_pkg.sv
      - hdl/afifo_sync_pkg.sv
      - hdl/bit_synchronizer.sv
      - hdl/gray_pointer.sv
      - hdl/fifo_storage.sv
      - hdl/write_side_ctrl.sv
      - hdl/read_side_ctrl.sv
      - hdl/async_fifo_top.sv
  # testbench and bound assertions
  - target: test
    files:
      - test/async_fifo_props.sv
      - test/async_fifo_tb.sv
